// File: flist.f
hdl/riscv_pkg.sv
hdl/fwd_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/riscv_core.sv
tests/riscv_core_checker.sv
tests/riscv_core_tb.sv

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import riscv_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  if_id_t           if_id_i,
   input  logic             flush_i,
   input  logic             rf_we_i,
   input  logic [REG_W-1:0] rf_rd_i,
   input  logic [XLEN-1:0]  rf_data_i,
   output id_ex_t           id_ex_o
);

   logic [XLEN-1:0]  regs [NUM_REGS];
   logic [XLEN-1:0]  instr;
   opcode_e          opc;
   logic [2:0]       funct3;
   logic [6:0]       funct7;
   logic [REG_W-1:0] rs1;
   logic [REG_W-1:0] rs2;
   logic [XLEN-1:0]  rs1_val;
   logic [XLEN-1:0]  rs2_val;
   logic [XLEN-1:0]  imm_i, imm_s, imm_b, imm_j, imm_u;
   logic             legal;
   id_ex_t           dec;

   assign instr  = if_id_i.instr;
   assign opc    = opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};

   // x0 reads zero, same-cycle write passes straight through
   assign rs1_val = (rs1 == '0) ? '0 : (rf_we_i && rf_rd_i == rs1) ? rf_data_i : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 : (rf_we_i && rf_rd_i == rs2) ? rf_data_i : regs[rs2];

   always_comb begin
      dec        = '0;
      legal      = 1'b1;
      dec.valid  = 1'b1;
      dec.pc     = if_id_i.pc;
      dec.rs1    = rs1;
      dec.rs2    = rs2;
      dec.rd     = instr[11:7];
      dec.op_a   = rs1_val;
      dec.op_b   = rs2_val;
      dec.imm    = imm_i;
      dec.alu_op = ALU_ADD;
      case (opc)
         OP_REG, OP_IMM: begin
            dec.reg_write = 1'b1;
            dec.use_imm   = (opc == OP_IMM);
            case (funct3)
               3'b000: dec.alu_op = (opc == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
               3'b010: dec.alu_op = ALU_SLT;
               3'b100: dec.alu_op = ALU_XOR;
               3'b110: dec.alu_op = ALU_OR;
               3'b111: dec.alu_op = ALU_AND;
               default: legal = 1'b0;
            endcase
            // Only SUB may set funct7
            if (opc == OP_REG && funct7 != 7'b0000000 &&
                !(funct3 == 3'b000 && funct7 == 7'b0100000)) begin
               legal = 1'b0;
            end
         end
         OP_LUI: begin
            dec.reg_write = 1'b1;
            dec.use_imm   = 1'b1;
            dec.imm       = imm_u;
            dec.alu_op    = ALU_PASS_B;
         end
         OP_LOAD: begin
            legal         = (funct3 == 3'b010);   // LW only
            dec.reg_write = 1'b1;
            dec.mem_read  = 1'b1;
            dec.use_imm   = 1'b1;
         end
         OP_STORE: begin
            legal         = (funct3 == 3'b010);   // SW only
            dec.mem_write = 1'b1;
            dec.use_imm   = 1'b1;
            dec.imm       = imm_s;
         end
         OP_BRANCH: begin
            legal         = (funct3[2:1] == 2'b00);
            dec.is_branch = 1'b1;
            dec.branch_ne = funct3[0];
            dec.imm       = imm_b;
         end
         OP_JAL: begin
            dec.reg_write = 1'b1;
            dec.is_jal    = 1'b1;
            dec.imm       = imm_j;
         end
         default: legal = 1'b0;
      endcase
      if (!(if_id_i.valid && legal)) begin
         dec = '0;   // Bubble
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_we_i) begin
         regs[rf_rd_i] <= rf_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush_i) begin
         id_ex_o <= '0;
      end else begin
         id_ex_o <= dec;
      end
   end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import riscv_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  id_ex_t  id_ex_i,
   input  logic    flush_i,
   fwd_if.sink     fwd,
   output ex_mem_t ex_mem_o
);

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_b;
   logic [XLEN-1:0] alu_out;
   logic            equal;
   logic            taken;
   ex_mem_t         ex_next;

   // Memory stage match wins over writeback
   function automatic logic [XLEN-1:0] pick_operand(
      input logic [REG_W-1:0] rs,
      input logic [XLEN-1:0]  rf_val,
      input logic [REG_W-1:0] mem_rd,
      input logic             mem_we,
      input logic [XLEN-1:0]  mem_result,
      input logic [REG_W-1:0] wb_rd,
      input logic             wb_we,
      input logic [XLEN-1:0]  wb_result
   );
      if (rs != '0 && mem_we && mem_rd == rs) begin
         return mem_result;
      end else if (rs != '0 && wb_we && wb_rd == rs) begin
         return wb_result;
      end
      return rf_val;
   endfunction

   assign op_a = pick_operand(id_ex_i.rs1, id_ex_i.op_a, fwd.mem_rd, fwd.mem_we,
                              fwd.mem_result, fwd.wb_rd, fwd.wb_we, fwd.wb_result);
   assign op_b = pick_operand(id_ex_i.rs2, id_ex_i.op_b, fwd.mem_rd, fwd.mem_we,
                              fwd.mem_result, fwd.wb_rd, fwd.wb_we, fwd.wb_result);

   assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;

   always_comb begin
      case (id_ex_i.alu_op)
         ALU_ADD:    alu_out = op_a + alu_b;
         ALU_SUB:    alu_out = op_a - alu_b;
         ALU_AND:    alu_out = op_a & alu_b;
         ALU_OR:     alu_out = op_a | alu_b;
         ALU_XOR:    alu_out = op_a ^ alu_b;
         ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
         ALU_PASS_B: alu_out = alu_b;
         default:    alu_out = '0;
      endcase
   end

   assign equal = (op_a == op_b);
   assign taken = id_ex_i.is_jal ||
                  (id_ex_i.is_branch && (id_ex_i.branch_ne ? !equal : equal));

   always_comb begin
      ex_next             = '0;
      ex_next.valid       = id_ex_i.valid;
      ex_next.pc          = id_ex_i.pc;
      ex_next.rd          = id_ex_i.rd;
      ex_next.alu_result  = id_ex_i.is_jal ? id_ex_i.pc + 32'd4 : alu_out;   // Link address
      ex_next.store_data  = op_b;
      ex_next.reg_write   = id_ex_i.reg_write;
      ex_next.mem_read    = id_ex_i.mem_read;
      ex_next.mem_write   = id_ex_i.mem_write;
      ex_next.redirect    = id_ex_i.valid && taken;
      ex_next.redirect_pc = id_ex_i.pc + id_ex_i.imm;
   end

   always_ff @(posedge clk) begin
      if (reset || flush_i) begin
         ex_mem_o <= '0;
      end else begin
         ex_mem_o <= ex_next;
      end
   end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import riscv_pkg::*; #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          imem_we_i,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
   input  logic [XLEN-1:0]               imem_data_i,
   input  logic                          redirect_i,
   input  logic [XLEN-1:0]               redirect_pc_i,
   output if_id_t                        if_id_o
);

   localparam int AW = $clog2(IMEM_WORDS);

   logic [XLEN-1:0] imem [IMEM_WORDS];
   logic [XLEN-1:0] pc;
   logic [AW-1:0]   pc_idx;

   assign pc_idx = pc[AW+1:2];   // Word index

   // Load port, usable in any cycle
   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         if_id_o <= '0;
      end else if (redirect_i) begin
         pc      <= redirect_pc_i;
         if_id_o <= '0;   // Drop the wrong-path fetch
      end else begin
         pc            <= pc + 32'd4;
         if_id_o.valid <= 1'b1;
         if_id_o.pc    <= pc;
         if_id_o.instr <= imem[pc_idx];
      end
   end

endmodule

// File: hdl/fwd_if.sv
`timescale 1ns/1ps

interface fwd_if import riscv_pkg::*; ();

   // Memory stage destination
   logic [REG_W-1:0] mem_rd;
   logic             mem_we;
   logic [XLEN-1:0]  mem_result;

   // Writeback stage destination
   logic [REG_W-1:0] wb_rd;
   logic             wb_we;
   logic [XLEN-1:0]  wb_result;

   modport mem_src (output mem_rd, mem_we, mem_result);
   modport wb_src  (output wb_rd, wb_we, wb_result);
   modport sink    (input mem_rd, mem_we, mem_result, wb_rd, wb_we, wb_result);

endinterface

// File: hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import riscv_pkg::*; #(
   parameter int DMEM_WORDS = 256
) (
   input  logic    clk,
   input  logic    reset,
   input  ex_mem_t ex_mem_i,
   fwd_if.mem_src  fwd_mem,
   fwd_if.wb_src   fwd_wb,
   output mem_wb_t mem_wb_o
);

   localparam int AW = $clog2(DMEM_WORDS);

   logic [XLEN-1:0] dmem [DMEM_WORDS];
   logic [AW-1:0]   addr;
   logic [XLEN-1:0] load_data;
   logic [XLEN-1:0] result;

   assign addr      = ex_mem_i.alu_result[AW+1:2];
   assign load_data = dmem[addr];   // Async read
   assign result    = ex_mem_i.mem_read ? load_data : ex_mem_i.alu_result;

   always_ff @(posedge clk) begin
      if (ex_mem_i.valid && ex_mem_i.mem_write) begin
         dmem[addr] <= ex_mem_i.store_data;
      end
   end

   assign fwd_mem.mem_rd     = ex_mem_i.rd;
   assign fwd_mem.mem_we     = ex_mem_i.valid && ex_mem_i.reg_write;
   assign fwd_mem.mem_result = result;

   assign fwd_wb.wb_rd     = mem_wb_o.rd;
   assign fwd_wb.wb_we     = mem_wb_o.valid && mem_wb_o.reg_write;
   assign fwd_wb.wb_result = mem_wb_o.result;

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb_o <= '0;
      end else begin
         mem_wb_o.valid     <= ex_mem_i.valid;
         mem_wb_o.pc        <= ex_mem_i.pc;
         mem_wb_o.rd        <= ex_mem_i.rd;
         mem_wb_o.reg_write <= ex_mem_i.reg_write;
         mem_wb_o.result    <= result;
      end
   end

endmodule

// File: hdl/riscv_core.sv
`timescale 1ns/1ps

module riscv_core import riscv_pkg::*; #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          imem_we_i,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
   input  logic [XLEN-1:0]               imem_data_i,
   output logic                          wb_valid_o,
   output logic [REG_W-1:0]              wb_rd_o,
   output logic [XLEN-1:0]               wb_data_o,
   output logic [XLEN-1:0]               wb_pc_o
);

   if_id_t  if_id;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   mem_wb_t mem_wb;

   fwd_if fwd ();

   // Also the register-file write enable
   assign wb_valid_o = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);
   assign wb_rd_o    = mem_wb.rd;
   assign wb_data_o  = mem_wb.result;
   assign wb_pc_o    = mem_wb.pc;

   fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
      .clk          (clk),
      .reset        (reset),
      .imem_we_i    (imem_we_i),
      .imem_addr_i  (imem_addr_i),
      .imem_data_i  (imem_data_i),
      .redirect_i   (ex_mem.redirect),
      .redirect_pc_i(ex_mem.redirect_pc),
      .if_id_o      (if_id)
   );

   decode_stage u_decode (
      .clk      (clk),
      .reset    (reset),
      .if_id_i  (if_id),
      .flush_i  (ex_mem.redirect),
      .rf_we_i  (wb_valid_o),
      .rf_rd_i  (mem_wb.rd),
      .rf_data_i(mem_wb.result),
      .id_ex_o  (id_ex)
   );

   execute_stage u_execute (
      .clk     (clk),
      .reset   (reset),
      .id_ex_i (id_ex),
      .flush_i (ex_mem.redirect),
      .fwd     (fwd),
      .ex_mem_o(ex_mem)
   );

   mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
      .clk     (clk),
      .reset   (reset),
      .ex_mem_i(ex_mem),
      .fwd_mem (fwd),
      .fwd_wb  (fwd),
      .mem_wb_o(mem_wb)
   );

endmodule

// File: hdl/riscv_pkg.sv
package riscv_pkg;

   localparam int XLEN     = 32;
   localparam int REG_W    = 5;
   localparam int NUM_REGS = 32;

   // RV32I major opcodes
   typedef enum logic [6:0] {
      OP_REG    = 7'b0110011,
      OP_IMM    = 7'b0010011,
      OP_LUI    = 7'b0110111,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B   // LUI
   } alu_op_e;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic             valid;
      logic [XLEN-1:0]  pc;
      logic [REG_W-1:0] rs1;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rd;
      logic [XLEN-1:0]  op_a;
      logic [XLEN-1:0]  op_b;
      logic [XLEN-1:0]  imm;
      alu_op_e          alu_op;
      logic             use_imm;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             is_branch;
      logic             branch_ne;
      logic             is_jal;
   } id_ex_t;

   typedef struct packed {
      logic             valid;
      logic [XLEN-1:0]  pc;
      logic [REG_W-1:0] rd;
      logic [XLEN-1:0]  alu_result;
      logic [XLEN-1:0]  store_data;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             redirect;
      logic [XLEN-1:0]  redirect_pc;
   } ex_mem_t;

   typedef struct packed {
      logic             valid;
      logic [XLEN-1:0]  pc;
      logic [REG_W-1:0] rd;
      logic             reg_write;
      logic [XLEN-1:0]  result;
   } mem_wb_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module riscv_core_tb \
   --Mdir obj_dir -o riscv_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/riscv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
   exit 0
fi
echo "Pass message not found"
exit 1

// File: tests/riscv_core_checker.sv
`timescale 1ns/1ps

module riscv_core_checker import riscv_pkg::*; (
   input logic             clk,
   input logic             reset,
   input logic             wb_valid_i,
   input logic [REG_W-1:0] wb_rd_i,
   input logic [XLEN-1:0]  wb_data_i
);

   // x0 writes are filtered before the port
   assert property (@(posedge clk) wb_valid_i |-> wb_rd_i != '0)
      else $error("writeback reported for register x0");

   // mem_wb is cleared by reset, so nothing retires during reset or one cycle later
   assert property (@(posedge clk) reset |=> !wb_valid_i)
      else $error("writeback valid during or right after reset");

   assert property (@(posedge clk) wb_valid_i |-> !$isunknown(wb_data_i))
      else $error("writeback data unknown while valid");

endmodule

bind riscv_core riscv_core_checker u_checker (
   .clk       (clk),
   .reset     (reset),
   .wb_valid_i(wb_valid_o),
   .wb_rd_i   (wb_rd_o),
   .wb_data_i (wb_data_o)
);

// File: tests/riscv_core_tb.sv
`timescale 1ns/1ps

module riscv_core_tb;

   localparam int CLK_PERIOD  = 4;
   localparam int NUM_TESTS   = 6;
   localparam int WATCHDOG_NS = NUM_TESTS * 80 * CLK_PERIOD;

   typedef enum {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT} alu_kind_e;

   logic        clk;
   logic        reset;
   logic        imem_we_i;
   logic [7:0]  imem_addr_i;
   logic [31:0] imem_data_i;
   logic        wb_valid_o;
   logic [4:0]  wb_rd_o;
   logic [31:0] wb_data_o;
   logic [31:0] wb_pc_o;

   logic [31:0] prog [$];
   logic [31:0] exp_rd [$];
   logic [31:0] exp_data [$];
   logic [31:0] exp_pc [$];
   logic [31:0] xreg [32];                  // Architectural register model
   logic [31:0] dmodel [logic [31:0]];      // Data memory model keyed by byte address
   int          dead;                       // Instructions left on a skipped path

   riscv_core UUT (
      .clk        (clk),
      .reset      (reset),
      .imem_we_i  (imem_we_i),
      .imem_addr_i(imem_addr_i),
      .imem_data_i(imem_data_i),
      .wb_valid_o (wb_valid_o),
      .wb_rd_o    (wb_rd_o),
      .wb_data_o  (wb_data_o),
      .wb_pc_o    (wb_pc_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_with(input string what);
      $display("ERROR at %0t: %s", $time, what);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
         $display("TESTBENCH FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      fail_with("watchdog timeout, the tests did not finish in time");
   end

   // Instruction encoders
   function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   function automatic logic [2:0] funct3_of(input alu_kind_e k);
      case (k)
         K_SLT:   return 3'b010;
         K_XOR:   return 3'b100;
         K_OR:    return 3'b110;
         K_AND:   return 3'b111;
         default: return 3'b000;   // ADD, SUB
      endcase
   endfunction

   // RV32I result rules
   function automatic logic [31:0] alu_ref(input alu_kind_e k, input logic [31:0] a,
                                           input logic [31:0] b);
      case (k)
         K_ADD:   return a + b;
         K_SUB:   return a - b;
         K_AND:   return a & b;
         K_OR:    return a | b;
         K_XOR:   return a ^ b;
         default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      endcase
   endfunction

   task automatic new_program();
      prog.delete();
      exp_rd.delete();
      exp_data.delete();
      exp_pc.delete();
      xreg = '{default: '0};   // Reset clears the register file
      dead = 0;
   endtask

   task automatic append_instr(input logic [31:0] word, input logic [4:0] rd,
                               input logic [31:0] value, input bit writes);
      logic [31:0] pc;
      pc = 32'(prog.size()) * 32'd4;
      prog.push_back(word);
      if (dead > 0) begin
         dead = dead - 1;   // Flushed by an older taken branch
      end else if (writes && rd != 5'd0) begin
         xreg[rd] = value;
         exp_rd.push_back(32'(rd));
         exp_data.push_back(value);
         exp_pc.push_back(pc);
      end
   endtask

   task automatic alu_reg(input alu_kind_e k, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
      logic [6:0] f7;
      f7 = (k == K_SUB) ? 7'b0100000 : 7'b0000000;
      append_instr(r_word(f7, rs2, rs1, funct3_of(k), rd), rd,
                   alu_ref(k, xreg[rs1], xreg[rs2]), 1'b1);
   endtask

   task automatic alu_imm(input alu_kind_e k, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
      append_instr(i_word(imm, rs1, funct3_of(k), rd, 7'b0010011), rd,
                   alu_ref(k, xreg[rs1], sext12(imm)), 1'b1);
   endtask

   task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
      append_instr(u_word(imm, rd), rd, {imm, 12'h000}, 1'b1);
   endtask

   task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
      logic [31:0] addr;
      logic [31:0] value;
      addr  = xreg[rs1] + sext12(imm);
      value = (dead == 0) ? dmodel[addr] : 32'd0;
      append_instr(i_word(imm, rs1, 3'b010, rd, 7'b0000011), rd, value, 1'b1);
   endtask

   task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                             input logic [11:0] imm);
      logic [31:0] addr;
      addr = xreg[rs1] + sext12(imm);
      if (dead == 0) begin
         dmodel[addr] = xreg[rs2];
      end
      append_instr(s_word(imm, rs2, rs1), 5'd0, 32'd0, 1'b0);
   endtask

   task automatic cond_branch(input bit ne, input logic [4:0] rs1, input logic [4:0] rs2,
                              input int off);
      bit live;
      bit taken;
      live  = (dead == 0);
      taken = ne ? (xreg[rs1] != xreg[rs2]) : (xreg[rs1] == xreg[rs2]);
      append_instr(b_word(13'(off), rs2, rs1, {2'b00, ne}), 5'd0, 32'd0, 1'b0);
      if (live && taken) begin
         dead = off / 4 - 1;
      end
   endtask

   task automatic jump_link(input logic [4:0] rd, input int off);
      bit          live;
      logic [31:0] link;
      live = (dead == 0);
      link = 32'(prog.size()) * 32'd4 + 32'd4;
      append_instr(j_word(21'(off), rd), rd, link, 1'b1);
      if (live) begin
         dead = off / 4 - 1;
      end
   endtask

   // Writes the program during reset and closes it with a self-branch
   task automatic load_program();
      @(negedge clk);
      reset = 1'b1;
      prog.push_back(b_word(13'd0, 5'd0, 5'd0, 3'b000));
      foreach (prog[i]) begin
         @(negedge clk);
         if (wb_valid_o) fail_with("writeback seen while reset is high");
         imem_we_i   = 1'b1;
         imem_addr_i = 8'(i);
         imem_data_i = prog[i];
      end
      @(negedge clk);
      imem_we_i = 1'b0;
      repeat (8) begin
         @(negedge clk);
         if (wb_valid_o) fail_with("writeback seen while reset is high");
      end
      reset = 1'b0;
   endtask

   // A negative count takes the whole list and then watches for extras
   task automatic collect_writebacks(input int count);
      int got;
      int cycles;
      int want;
      int limit;
      got    = 0;
      cycles = 0;
      want   = (count < 0) ? exp_rd.size() : count;
      limit  = prog.size() + 16;
      while (got < want) begin
         @(negedge clk);
         cycles++;
         if (wb_valid_o) begin
            check_value("wb_rd_o", 32'(wb_rd_o), exp_rd[got]);
            check_value("wb_data_o", wb_data_o, exp_data[got]);
            check_value("wb_pc_o", wb_pc_o, exp_pc[got]);
            got++;
         end else if (cycles > limit) begin
            fail_with($sformatf("missing writeback, only %0d of %0d seen", got, want));
         end
      end
      if (count < 0) begin
         repeat (8) begin
            @(negedge clk);
            if (wb_valid_o) begin
               fail_with($sformatf("extra writeback to x%0d from pc %h", wb_rd_o, wb_pc_o));
            end
         end
      end
   endtask

   task automatic alu_chain();
      logic [11:0] i1;
      logic [11:0] i2;
      logic [19:0] u;
      i1 = 12'($urandom);
      i2 = 12'($urandom);
      u  = 20'($urandom);
      $display("Running ALU and forwarding test");
      new_program();
      alu_imm(K_ADD, 1, 0, i1);
      alu_imm(K_ADD, 2, 0, i2);
      alu_reg(K_ADD, 3, 1, 2);   // x2 from memory stage and x1 from writeback
      alu_reg(K_SUB, 4, 3, 1);
      alu_reg(K_AND, 5, 4, 3);
      alu_reg(K_OR,  6, 5, 4);
      alu_reg(K_XOR, 7, 6, 5);
      alu_reg(K_SLT, 8, 7, 6);
      load_upper(9, u);
      alu_imm(K_XOR, 10, 9, i1);
      alu_imm(K_OR,  11, 10, i2);
      alu_imm(K_AND, 12, 9, i2);
      alu_imm(K_SLT, 13, 11, i1);
      alu_reg(K_SLT, 14, 2, 1);
      load_program();
      collect_writebacks(-1);
   endtask

   task automatic load_store();
      $display("Running load and store test");
      new_program();
      alu_imm(K_ADD, 1, 0, 12'($urandom));
      alu_imm(K_ADD, 2, 0, 12'h040);
      store_word(1, 2, 12'h008);
      load_word(3, 2, 12'h008);
      alu_reg(K_ADD, 4, 3, 1);   // Load result used right away
      store_word(4, 2, 12'hffc);
      load_word(5, 2, 12'hffc);
      alu_imm(K_XOR, 6, 5, 12'h123);
      load_word(7, 0, 12'h048);
      load_program();
      collect_writebacks(-1);
   endtask

   task automatic branch_skip();
      $display("Running branch test");
      new_program();
      alu_imm(K_ADD, 1, 0, 12'($urandom));
      alu_imm(K_ADD, 2, 1, 12'h000);
      cond_branch(1'b0, 1, 2, 16);   // BEQ taken
      alu_imm(K_ADD, 10, 0, 12'h001);
      alu_imm(K_ADD, 11, 0, 12'h002);
      alu_imm(K_ADD, 12, 0, 12'h003);
      alu_imm(K_ADD, 3, 0, 12'h005);
      cond_branch(1'b1, 3, 0, 16);   // BNE taken
      alu_imm(K_ADD, 13, 0, 12'h001);
      alu_imm(K_ADD, 14, 0, 12'h002);
      alu_imm(K_ADD, 15, 0, 12'h003);
      alu_imm(K_ADD, 4, 3, 12'h001);
      cond_branch(1'b0, 3, 0, 16);   // Falls through
      alu_imm(K_ADD, 5, 4, 12'h001);
      alu_imm(K_ADD, 6, 5, 12'h001);
      cond_branch(1'b1, 1, 2, 16);
      alu_imm(K_ADD, 7, 6, 12'h001);
      alu_imm(K_ADD, 8, 7, 12'h001);
      load_program();
      collect_writebacks(-1);
   endtask

   task automatic jal_link();
      $display("Running JAL test");
      new_program();
      alu_imm(K_ADD, 1, 0, 12'($urandom));
      jump_link(5, 16);
      alu_imm(K_ADD, 10, 0, 12'h001);
      alu_imm(K_ADD, 11, 0, 12'h002);
      alu_imm(K_ADD, 12, 0, 12'h003);
      alu_reg(K_ADD, 6, 5, 1);   // Jump target
      jump_link(0, 8);
      alu_imm(K_ADD, 13, 0, 12'h004);
      alu_reg(K_ADD, 7, 6, 1);
      load_program();
      collect_writebacks(-1);
   endtask

   task automatic x0_hardwired();
      $display("Running x0 test");
      new_program();
      alu_imm(K_ADD, 0, 0, 12'($urandom));
      alu_imm(K_ADD, 1, 0, 12'($urandom));
      alu_imm(K_ADD, 0, 1, 12'h7ff);
      alu_reg(K_ADD, 2, 0, 1);   // x0 must not pick up the write before it
      alu_reg(K_ADD, 3, 1, 0);
      load_upper(0, 20'($urandom));
      alu_reg(K_OR, 4, 0, 1);
      load_program();
      collect_writebacks(-1);
   endtask

   task automatic mid_program_reset();
      logic [11:0] a;
      logic [11:0] b;
      a = (12'($urandom) & 12'h7ff) | 12'h001;   // Positive so a stale x1 + x2 is never zero
      b = (12'($urandom) & 12'h7ff) | 12'h001;
      $display("Running reset test");
      new_program();
      alu_imm(K_ADD, 1, 0, a);
      alu_imm(K_ADD, 2, 0, b);
      for (int i = 3; i < 9; i++) begin
         alu_imm(K_ADD, 5'(i), 1, 12'(i));
      end
      load_program();
      collect_writebacks(2);   // Reset hits while the rest is in flight
      new_program();
      alu_reg(K_ADD, 3, 1, 2);
      alu_imm(K_ADD, 4, 3, a);
      load_program();
      collect_writebacks(-1);
   endtask

   initial begin
      reset       = 1'b1;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      dead        = 0;
      void'($urandom(72));
      repeat (8) @(negedge clk);
      alu_chain();
      load_store();
      branch_skip();
      jal_link();
      x0_hardwired();
      mid_program_reset();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
